//--- boa_board.f
rtl/boa_pkg.sv
rtl/boa_addr_decode.sv
rtl/boa_extmem_sram.sv
rtl/boa_gpio.sv
rtl/boa_pmu.sv
rtl/boa_board.sv
test/boa_tb_clock.sv
test/boa_board_chk.sv
test/boa_board_tb.sv

//--- rtl/boa_addr_decode.sv
// Bus address decoder
`timescale 1ns/1ps
`default_nettype none

module boa_addr_decode #(
    parameter int sram_addr_width = 19
) (
    input  logic              clk,
    input  logic              rst_n,
    input  boa_pkg::mem_req_t bus_req,
    output boa_pkg::mem_rsp_t bus_rsp,
    output boa_pkg::mem_req_t sram_req,
    output boa_pkg::mem_req_t gpio_req,
    output boa_pkg::mem_req_t pmu_req,
    input  boa_pkg::mem_rsp_t sram_rsp,
    input  boa_pkg::mem_rsp_t gpio_rsp,
    input  boa_pkg::mem_rsp_t pmu_rsp
);
    localparam logic [31:0] xmsize_value = 32'd1 << sram_addr_width;

    logic              pending_q;
    boa_pkg::target_t  tgt_q;
    boa_pkg::target_t  tgt_d;
    boa_pkg::mem_req_t req_q;
    boa_pkg::mem_rsp_t sel_rsp;
    boa_pkg::mem_rsp_t local_rsp;
    logic              local_sel;
    logic              bus_valid;

    // Keep the enables only for the selected target.
    function automatic boa_pkg::mem_req_t gate_req(input boa_pkg::mem_req_t r, input logic sel);
        boa_pkg::mem_req_t g;
        g    = r;
        g.re = r.re & sel;
        g.we = r.we & {4{sel}};
        return g;
    endfunction

    assign bus_valid = bus_req.re || (|bus_req.we);

    always_comb begin
        if (bus_req.addr[31:sram_addr_width] == boa_pkg::sram_base[31:sram_addr_width]) begin
            tgt_d = boa_pkg::tgt_sram;
        end else if (bus_req.addr[31:4] == boa_pkg::gpio_base[31:4]) begin
            tgt_d = boa_pkg::tgt_gpio;
        end else if (bus_req.addr[31:2] == boa_pkg::pmu_base[31:2]) begin
            tgt_d = boa_pkg::tgt_pmu;
        end else if (bus_req.addr[31:2] == boa_pkg::xmsize_addr[31:2]) begin
            tgt_d = boa_pkg::tgt_xmsize;
        end else begin
            tgt_d = boa_pkg::tgt_none;
        end
    end

    // One request in flight; the held bus request waits while pending.
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            pending_q <= 1'b0;
            tgt_q     <= boa_pkg::tgt_none;
        end else if (!pending_q && bus_valid) begin
            pending_q <= 1'b1;
            tgt_q     <= tgt_d;
        end else if (bus_rsp.ready) begin
            pending_q <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (!pending_q && bus_valid) begin
            req_q <= bus_req;
        end
    end

    assign sram_req = gate_req(req_q, pending_q && tgt_q == boa_pkg::tgt_sram);
    assign gpio_req = gate_req(req_q, pending_q && tgt_q == boa_pkg::tgt_gpio);
    assign pmu_req  = gate_req(req_q, pending_q && tgt_q == boa_pkg::tgt_pmu);

    // Memory size register and unmapped space answer here.
    assign local_sel = pending_q &&
                       (tgt_q == boa_pkg::tgt_xmsize || tgt_q == boa_pkg::tgt_none);

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            local_rsp.ready <= 1'b0;
        end else begin
            local_rsp.ready <= local_sel && !local_rsp.ready;
        end
    end

    always_ff @(posedge clk) begin
        local_rsp.rdata <= (tgt_q == boa_pkg::tgt_xmsize) ? xmsize_value : 32'd0;
    end

    always_comb begin
        case (tgt_q)
            boa_pkg::tgt_sram: sel_rsp = sram_rsp;
            boa_pkg::tgt_gpio: sel_rsp = gpio_rsp;
            boa_pkg::tgt_pmu:  sel_rsp = pmu_rsp;
            default:           sel_rsp = local_rsp;
        endcase
    end

    assign bus_rsp.ready = pending_q && sel_rsp.ready;
    assign bus_rsp.rdata = sel_rsp.rdata;

endmodule

`default_nettype wire

//--- rtl/boa_board.sv
// Board memory and peripheral subsystem
`timescale 1ns/1ps
`default_nettype none

module boa_board #(
    parameter int sram_addr_width = 19
) (
    input  logic                       clk,
    input  logic                       rst_n,
    // Memory bus from the core.
    input  boa_pkg::mem_req_t          bus_req,
    output boa_pkg::mem_rsp_t          bus_rsp,
    // Button 0 resets the system and button 1 is user input.
    input  logic [1:0]                 btn,
    output logic                       led_r,
    output logic                       led_g,
    output logic                       led_b,
    output logic [31:0]                gpio_out,
    output logic [31:0]                gpio_oe,
    // SRAM pins with the data bus split by direction.
    output logic                       sram_oe_n,
    output logic                       sram_we_n,
    output logic                       sram_ce_n,
    output logic [sram_addr_width-1:0] sram_addr,
    output logic [7:0]                 sram_wdata,
    output logic                       sram_data_oe,
    input  logic [7:0]                 sram_rdata,
    output logic                       shdn,
    output logic                       soc_rst
);
    boa_pkg::mem_req_t sram_req;
    boa_pkg::mem_req_t gpio_req;
    boa_pkg::mem_req_t pmu_req;
    boa_pkg::mem_rsp_t sram_rsp;
    boa_pkg::mem_rsp_t gpio_rsp;
    boa_pkg::mem_rsp_t pmu_rsp;

    boa_addr_decode #(
        .sram_addr_width (sram_addr_width)
    ) u_addr_decode (
        .clk      (clk),
        .rst_n    (rst_n),
        .bus_req  (bus_req),
        .bus_rsp  (bus_rsp),
        .sram_req (sram_req),
        .gpio_req (gpio_req),
        .pmu_req  (pmu_req),
        .sram_rsp (sram_rsp),
        .gpio_rsp (gpio_rsp),
        .pmu_rsp  (pmu_rsp)
    );

    boa_extmem_sram #(
        .sram_addr_width (sram_addr_width)
    ) u_extmem_sram (
        .clk          (clk),
        .rst_n        (rst_n),
        .req          (sram_req),
        .rsp          (sram_rsp),
        .sram_oe_n    (sram_oe_n),
        .sram_we_n    (sram_we_n),
        .sram_ce_n    (sram_ce_n),
        .sram_addr    (sram_addr),
        .sram_wdata   (sram_wdata),
        .sram_data_oe (sram_data_oe),
        .sram_rdata   (sram_rdata)
    );

    boa_gpio u_gpio (
        .clk      (clk),
        .rst_n    (rst_n),
        .soc_rst  (soc_rst),
        .req      (gpio_req),
        .rsp      (gpio_rsp),
        .btn_user (btn[1]),
        .led_r    (led_r),
        .led_g    (led_g),
        .led_b    (led_b),
        .gpio_out (gpio_out),
        .gpio_oe  (gpio_oe)
    );

    boa_pmu u_pmu (
        .clk       (clk),
        .rst_n     (rst_n),
        .req       (pmu_req),
        .rsp       (pmu_rsp),
        .btn_reset (btn[0]),
        .shdn      (shdn),
        .soc_rst   (soc_rst)
    );

endmodule

`default_nettype wire

//--- rtl/boa_extmem_sram.sv
// Byte-wide SRAM controller
`timescale 1ns/1ps
`default_nettype none

module boa_extmem_sram #(
    parameter int sram_addr_width = 19
) (
    input  logic                       clk,
    input  logic                       rst_n,
    input  boa_pkg::mem_req_t          req,
    output boa_pkg::mem_rsp_t          rsp,
    output logic                       sram_oe_n,
    output logic                       sram_we_n,
    output logic                       sram_ce_n,
    output logic [sram_addr_width-1:0] sram_addr,
    output logic [7:0]                 sram_wdata,
    output logic                       sram_data_oe,
    input  logic [7:0]                 sram_rdata
);
    logic        busy_q;
    logic        rd_q;
    logic        wr_q;
    logic        ready_q;
    logic [1:0]  lane_q;
    logic [31:0] rdata_q;
    logic        is_wr;
    logic        active;
    logic        load;
    logic [3:0]  lane_mask;
    logic [2:0]  from_lane;
    logic        next_found;
    logic [1:0]  next_lane;

    // Writes win over reads when both are set.
    assign is_wr     = |req.we;
    assign active    = (req.re || is_wr) && !ready_q;
    assign lane_mask = is_wr ? req.we : 4'b1111;
    assign from_lane = busy_q ? {1'b0, lane_q} + 3'd1 : 3'd0;

    // Lowest enabled lane at or above from_lane.
    always_comb begin
        next_found = 1'b0;
        next_lane  = 2'd0;
        for (int i = 3; i >= 0; i--) begin
            if (lane_mask[i] && (3'(i) >= from_lane)) begin
                next_found = 1'b1;
                next_lane  = 2'(i);
            end
        end
    end

    assign load = busy_q ? next_found : active;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            busy_q  <= 1'b0;
            rd_q    <= 1'b0;
            wr_q    <= 1'b0;
            ready_q <= 1'b0;
            lane_q  <= 2'd0;
        end else begin
            ready_q <= 1'b0;
            if (load) begin
                busy_q <= 1'b1;
                rd_q   <= !is_wr;
                wr_q   <= is_wr;
                lane_q <= next_lane;
            end else if (busy_q) begin
                // Last lane done.
                busy_q  <= 1'b0;
                rd_q    <= 1'b0;
                wr_q    <= 1'b0;
                ready_q <= 1'b1;
            end
        end
    end

    // Address and write byte change together with the strobes.
    always_ff @(posedge clk) begin
        if (load) begin
            sram_addr  <= {req.addr[sram_addr_width-1:2], next_lane};
            sram_wdata <= req.wdata[{next_lane, 3'b000} +: 8];
        end
    end

    // Read bytes land in their lane, least significant first.
    always_ff @(posedge clk) begin
        if (rd_q) begin
            rdata_q[{lane_q, 3'b000} +: 8] <= sram_rdata;
        end
    end

    assign sram_oe_n    = !rd_q;
    assign sram_we_n    = !wr_q;
    assign sram_data_oe = wr_q;
    assign sram_ce_n    = 1'b0;

    assign rsp.ready = ready_q;
    assign rsp.rdata = rdata_q;

endmodule

`default_nettype wire

//--- rtl/boa_gpio.sv
// GPIO registers and LEDs
`timescale 1ns/1ps
`default_nettype none

module boa_gpio (
    input  logic              clk,
    input  logic              rst_n,
    input  logic              soc_rst,
    input  boa_pkg::mem_req_t req,
    output boa_pkg::mem_rsp_t rsp,
    input  logic              btn_user,
    output logic              led_r,
    output logic              led_g,
    output logic              led_b,
    output logic [31:0]       gpio_out,
    output logic [31:0]       gpio_oe
);
    logic        fire;
    logic        ready_q;
    logic [31:0] rdata_q;
    logic        btn_meta;
    logic        btn_sync;
    logic [31:0] gpio_in;

    assign fire = (req.re || (|req.we)) && !ready_q;

    // Two-flop button synchronizer.
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            btn_meta <= 1'b0;
            btn_sync <= 1'b0;
        end else begin
            btn_meta <= btn_user;
            btn_sync <= btn_meta;
        end
    end

    assign gpio_in = {gpio_out[31:12], btn_sync, gpio_out[10:0]};

    // System reset from the PMU also clears the pins.
    always_ff @(posedge clk) begin
        if (!rst_n || soc_rst) begin
            gpio_out <= 32'd0;
            gpio_oe  <= 32'd0;
            ready_q  <= 1'b0;
        end else begin
            ready_q <= fire;
            for (int b = 0; b < 4; b++) begin
                if (fire && req.we[b]) begin
                    if (req.addr == boa_pkg::gpio_out_addr) begin
                        gpio_out[b*8 +: 8] <= req.wdata[b*8 +: 8];
                    end
                    if (req.addr == boa_pkg::gpio_oe_addr) begin
                        gpio_oe[b*8 +: 8] <= req.wdata[b*8 +: 8];
                    end
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        case (req.addr)
            boa_pkg::gpio_out_addr: rdata_q <= gpio_out;
            boa_pkg::gpio_oe_addr:  rdata_q <= gpio_oe;
            boa_pkg::gpio_in_addr:  rdata_q <= gpio_in;
            default:                rdata_q <= 32'd0;
        endcase
    end

    assign rsp.ready = ready_q;
    assign rsp.rdata = rdata_q;

    // LEDs are active low.
    assign led_r = ~gpio_out[8];
    assign led_g = ~gpio_out[9];
    assign led_b = ~gpio_out[10];

endmodule

`default_nettype wire

//--- rtl/boa_pkg.sv
// Board bus types and address map
`default_nettype none

package boa_pkg;

    // One memory bus request that the master holds until ready.
    typedef struct packed {
        logic        re;
        logic [3:0]  we;
        logic [31:0] addr;
        logic [31:0] wdata;
    } mem_req_t;

    // Response with a one-cycle ready pulse.
    typedef struct packed {
        logic        ready;
        logic [31:0] rdata;
    } mem_rsp_t;

    // Decoder targets.
    typedef enum logic [2:0] {
        tgt_sram,
        tgt_gpio,
        tgt_xmsize,
        tgt_pmu,
        tgt_none
    } target_t;

    // SRAM window whose size follows sram_addr_width.
    localparam logic [31:0] sram_base     = 32'h0000_0000;

    // GPIO register block.
    localparam logic [31:0] gpio_base     = 32'h1000_0000;
    localparam logic [31:0] gpio_out_addr = gpio_base + 32'h0;
    localparam logic [31:0] gpio_oe_addr  = gpio_base + 32'h4;
    localparam logic [31:0] gpio_in_addr  = gpio_base + 32'h8;

    // Power management register.
    localparam logic [31:0] pmu_base      = 32'h1000_0100;

    // Read-only external memory size.
    localparam logic [31:0] xmsize_addr   = 32'h1000_0600;

    // PMU register bits.
    localparam int pmu_shdn_bit = 0;
    localparam int pmu_rst_bit  = 1;

endpackage

`default_nettype wire

//--- rtl/boa_pmu.sv
// Power management unit
`timescale 1ns/1ps
`default_nettype none

module boa_pmu (
    input  logic              clk,
    input  logic              rst_n,
    input  boa_pkg::mem_req_t req,
    output boa_pkg::mem_rsp_t rsp,
    input  logic              btn_reset,
    output logic              shdn,
    output logic              soc_rst
);
    logic        fire;
    logic        reg_wr;
    logic        rst_req;
    logic        btn_trig;
    logic        ready_q;
    logic [31:0] rdata_q;
    logic [3:0]  btn_sr;

    assign fire   = (req.re || (|req.we)) && !ready_q;
    assign reg_wr = fire && req.we[0];

    // Synchronizer plus two delay stages.
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            btn_sr <= 4'd0;
        end else begin
            btn_sr <= {btn_sr[2:0], btn_reset};
        end
    end

    // Fires once per press after two synchronized cycles high.
    assign btn_trig = btn_sr[1] && btn_sr[2] && !btn_sr[3];
    assign rst_req  = btn_trig || (reg_wr && req.wdata[boa_pkg::pmu_rst_bit]);

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            shdn    <= 1'b0;
            soc_rst <= 1'b0;
            ready_q <= 1'b0;
        end else begin
            ready_q <= fire;
            soc_rst <= rst_req;
            if (rst_req) begin
                shdn <= 1'b0;
            end else if (reg_wr && req.wdata[boa_pkg::pmu_shdn_bit]) begin
                shdn <= 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        rdata_q <= 32'd0;
        rdata_q[boa_pkg::pmu_shdn_bit] <= shdn;
    end

    assign rsp.ready = ready_q;
    assign rsp.rdata = rdata_q;

endmodule

`default_nettype wire

//--- run.sh
#!/usr/bin/env bash
# Build and run the board testbench with Verilator.
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -j 0 \
    --top-module boa_board_tb \
    -f boa_board.f \
    --Mdir obj_dir \
    -o boa_board_sim

sim_out=$(./obj_dir/boa_board_sim)
echo "$sim_out"

if grep -qx "TESTS PASSED" <<< "$sim_out"; then
    exit 0
fi
exit 1

//--- test/boa_board_chk.sv
// Bus and SRAM pin checks
`timescale 1ns/1ps
`default_nettype none

module boa_board_chk (
    input logic              clk,
    input logic              rst_n,
    input boa_pkg::mem_rsp_t bus_rsp,
    input logic              sram_oe_n,
    input logic              sram_we_n,
    input logic              sram_data_oe,
    input logic              soc_rst
);
    // One ready pulse per request.
    ready_single: assert property (
        @(posedge clk) disable iff (!rst_n)
        bus_rsp.ready |=> !bus_rsp.ready
    ) else $error("bus ready high for two cycles in a row");

    // Never read and write the SRAM at once.
    sram_rd_wr_excl: assert property (
        @(posedge clk) disable iff (!rst_n)
        !(!sram_we_n && !sram_oe_n)
    ) else $error("sram_we_n and sram_oe_n both low");

    // Data bus driven only while writing.
    sram_drive_on_write: assert property (
        @(posedge clk) disable iff (!rst_n)
        sram_data_oe == !sram_we_n
    ) else $error("sram_data_oe does not follow sram_we_n");

    soc_rst_pulse: assert property (
        @(posedge clk) disable iff (!rst_n)
        soc_rst |=> !soc_rst
    ) else $error("soc_rst longer than one cycle");

endmodule

`default_nettype wire

//--- test/boa_board_tb.sv
// Board subsystem testbench
`timescale 1ns/1ps
`default_nettype none

module boa_board_tb;

    typedef enum logic [1:0] {op_write, op_read, op_button} op_t;
    typedef enum logic [2:0] {
        chk_none,
        chk_bytes,
        chk_pins,
        chk_oe,
        chk_shdn,
        chk_reset
    } chk_t;

    typedef struct {
        string       name;
        op_t         op;
        logic [31:0] addr;
        logic [3:0]  strb;
        logic [31:0] wdata;
        logic [31:0] exp_val;
        chk_t        chk;
    } entry_t;

    logic              clk;
    logic              rst_n;
    boa_pkg::mem_req_t bus_req;
    boa_pkg::mem_rsp_t bus_rsp;
    logic [1:0]        btn;
    logic              led_r;
    logic              led_g;
    logic              led_b;
    logic [31:0]       gpio_out;
    logic [31:0]       gpio_oe;
    logic              sram_oe_n;
    logic              sram_we_n;
    logic              sram_ce_n;
    logic [18:0]       sram_addr;
    logic [7:0]        sram_wdata;
    logic              sram_data_oe;
    logic [7:0]        sram_rdata;
    logic              shdn;
    logic              soc_rst;
    logic [7:0]        sram_mem [0:(1<<19)-1];
    entry_t            stim[$];
    logic              built = 1'b0;
    int                rst_pulses = 0;
    int                pass_count;
    int                fail_count;
    int                test_errors;

    boa_tb_clock #(.period_ns(20), .reset_cycles(2)) u_tb_clock (.clk(clk), .rst_n(rst_n));

    boa_board u_boa_board (
        .clk          (clk),
        .rst_n        (rst_n),
        .bus_req      (bus_req),
        .bus_rsp      (bus_rsp),
        .btn          (btn),
        .led_r        (led_r),
        .led_g        (led_g),
        .led_b        (led_b),
        .gpio_out     (gpio_out),
        .gpio_oe      (gpio_oe),
        .sram_oe_n    (sram_oe_n),
        .sram_we_n    (sram_we_n),
        .sram_ce_n    (sram_ce_n),
        .sram_addr    (sram_addr),
        .sram_wdata   (sram_wdata),
        .sram_data_oe (sram_data_oe),
        .sram_rdata   (sram_rdata),
        .shdn         (shdn),
        .soc_rst      (soc_rst)
    );

    bind boa_board boa_board_chk u_board_chk (
        .clk          (clk),
        .rst_n        (rst_n),
        .bus_rsp      (bus_rsp),
        .sram_oe_n    (sram_oe_n),
        .sram_we_n    (sram_we_n),
        .sram_data_oe (sram_data_oe),
        .soc_rst      (soc_rst)
    );

    // Asynchronous byte SRAM with active-low chip, output and write enables.
    assign sram_rdata = (!sram_ce_n && !sram_oe_n) ? sram_mem[sram_addr] : 8'hxx;

    // A byte is stored only while the controller drives the data bus.
    always @(posedge clk) begin
        if (!sram_ce_n && !sram_we_n && sram_data_oe) begin
            sram_mem[sram_addr] <= sram_wdata;
        end
    end

    always @(negedge clk) begin
        if (soc_rst) begin
            rst_pulses <= rst_pulses + 1;
        end
    end

    task automatic check(input string name, input logic [31:0] exp_v, input logic [31:0] act_v);
        if (act_v !== exp_v) begin
            $display("MISMATCH %s expected %08h actual %08h", name, exp_v, act_v);
            test_errors++;
        end
    endtask

    function automatic logic [31:0] merge_bytes(input logic [31:0] old_w, input logic [31:0] new_w,
                                                input logic [3:0] strb);
        logic [31:0] m;
        m = old_w;
        for (int b = 0; b < 4; b++) begin
            if (strb[b]) begin
                m[b*8 +: 8] = new_w[b*8 +: 8];
            end
        end
        return m;
    endfunction

    function automatic void add_entry(input string name, input op_t op, input logic [31:0] addr,
                                      input logic [3:0] strb, input logic [31:0] wdata,
                                      input logic [31:0] exp_val, input chk_t chk);
        entry_t e;
        e.name    = name;
        e.op      = op;
        e.addr    = addr;
        e.strb    = strb;
        e.wdata   = wdata;
        e.exp_val = exp_val;
        e.chk     = chk;
        stim.push_back(e);
    endfunction

    task automatic build_stimulus();
        logic [31:0] addr [4];
        logic [31:0] word [4];
        logic [31:0] data;
        logic [31:0] gpio_val;
        logic [31:0] shdn_w;
        logic [31:0] rst_w;
        shdn_w = 32'd1 << boa_pkg::pmu_shdn_bit;
        rst_w  = 32'd1 << boa_pkg::pmu_rst_bit;
        // Bits 18:17 hold the index so the words never overlap.
        for (int i = 0; i < 4; i++) begin
            addr[i] = {13'd0, 2'(i), 17'($urandom())} & 32'h0007_fffc;
            word[i] = $urandom();
            add_entry($sformatf("sram_wr%0d", i), op_write, addr[i], 4'hf, word[i], 0, chk_bytes);
        end
        for (int i = 0; i < 4; i++) begin
            add_entry($sformatf("sram_rd%0d", i), op_read, addr[i], 4'h0, 0, word[i], chk_none);
        end
        data    = $urandom();
        word[0] = merge_bytes(word[0], data, 4'b0101);
        add_entry("sram_part_wr0", op_write, addr[0], 4'b0101, data, 0, chk_none);
        add_entry("sram_part_rd0", op_read, addr[0], 4'h0, 0, word[0], chk_none);
        data    = $urandom();
        word[1] = merge_bytes(word[1], data, 4'b1000);
        add_entry("sram_part_wr1", op_write, addr[1], 4'b1000, data, 0, chk_none);
        add_entry("sram_part_rd1", op_read, addr[1], 4'h0, 0, word[1], chk_none);

        add_entry("xmsize_rd", op_read, boa_pkg::xmsize_addr, 4'h0, 0, 32'h0008_0000, chk_none);
        add_entry("unmapped_rd", op_read, 32'h2000_0000, 4'h0, 0, 32'h0, chk_none);
        add_entry("unmapped_io_rd", op_read, 32'h1000_0200, 4'h0, 0, 32'h0, chk_none);

        // Bit 11 set so the button replacement shows up.
        gpio_val = $urandom() | 32'h0000_0800;
        add_entry("gpio_out_wr", op_write, boa_pkg::gpio_out_addr, 4'hf, gpio_val, gpio_val,
                  chk_pins);
        add_entry("gpio_oe_wr", op_write, boa_pkg::gpio_oe_addr, 4'hf, 32'hffff_00ff,
                  32'hffff_00ff, chk_oe);
        add_entry("gpio_oe_rd", op_read, boa_pkg::gpio_oe_addr, 4'h0, 0, 32'hffff_00ff, chk_none);
        add_entry("gpio_out_rd", op_read, boa_pkg::gpio_out_addr, 4'h0, 0, gpio_val, chk_none);
        add_entry("gpio_in_btn_lo", op_read, boa_pkg::gpio_in_addr, 4'h0, 0,
                  gpio_val & ~32'h0000_0800, chk_none);
        add_entry("btn1_press", op_button, 0, 4'h0, 32'h2, 0, chk_none);
        add_entry("gpio_in_btn_hi", op_read, boa_pkg::gpio_in_addr, 4'h0, 0, gpio_val, chk_none);
        add_entry("btn1_release", op_button, 0, 4'h0, 32'h0, 0, chk_none);

        add_entry("pmu_shdn_wr", op_write, boa_pkg::pmu_base, 4'h1, shdn_w, 32'h1, chk_shdn);
        add_entry("pmu_shdn_rd", op_read, boa_pkg::pmu_base, 4'h0, 0, 32'h1, chk_none);
        add_entry("pmu_rst_wr", op_write, boa_pkg::pmu_base, 4'h1, rst_w, 0, chk_reset);
        add_entry("pmu_rd_after_rst", op_read, boa_pkg::pmu_base, 4'h0, 0, 32'h0, chk_none);
        add_entry("gpio_out_after_rst", op_read, boa_pkg::gpio_out_addr, 4'h0, 0, 0, chk_none);

        gpio_val = $urandom();
        add_entry("gpio_out_wr2", op_write, boa_pkg::gpio_out_addr, 4'hf, gpio_val, gpio_val,
                  chk_pins);
        add_entry("gpio_oe_wr2", op_write, boa_pkg::gpio_oe_addr, 4'hf, 32'h00ff_ff00,
                  32'h00ff_ff00, chk_oe);
        add_entry("pmu_shdn_wr2", op_write, boa_pkg::pmu_base, 4'h1, shdn_w, 32'h1, chk_shdn);
        add_entry("btn0_press", op_button, 0, 4'h0, 32'h1, 0, chk_reset);
        add_entry("btn0_release", op_button, 0, 4'h0, 32'h0, 0, chk_none);
        add_entry("gpio_out_after_btn", op_read, boa_pkg::gpio_out_addr, 4'h0, 0, 0, chk_none);
        add_entry("gpio_oe_after_btn", op_read, boa_pkg::gpio_oe_addr, 4'h0, 0, 0, chk_none);
    endtask

    // The request is held until ready and dropped on the edge that ends the ready cycle.
    task automatic bus_access(input boa_pkg::mem_req_t r, output logic [31:0] rdata,
                              output logic got);
        int n;
        got   = 1'b0;
        rdata = 32'd0;
        n     = 0;
        @(posedge clk);
        bus_req <= r;
        while (!got && n < 16) begin
            @(negedge clk);
            if (bus_rsp.ready) begin
                got   = 1'b1;
                rdata = bus_rsp.rdata;
            end
            n++;
        end
        @(posedge clk);
        bus_req <= '0;
    endtask

    task automatic run_entry(input entry_t e);
        boa_pkg::mem_req_t r;
        logic [31:0]       rdata;
        logic              got;
        int                pulses_before;
        test_errors   = 0;
        pulses_before = rst_pulses;
        r             = '0;
        r.addr        = e.addr;
        r.wdata       = e.wdata;
        if (e.op == op_write) begin
            r.we = e.strb;
        end else if (e.op == op_read) begin
            r.re = 1'b1;
        end
        if (e.op == op_button) begin
            @(posedge clk);
            btn <= e.wdata[1:0];
            repeat (6) @(posedge clk);
        end else begin
            bus_access(r, rdata, got);
            if (!got) begin
                $display("ERROR: %s got no ready within 16 cycles", e.name);
                test_errors++;
            end else if (e.op == op_read) begin
                check(e.name, e.exp_val, rdata);
            end
        end
        @(negedge clk);
        case (e.chk)
            chk_bytes: begin
                // Little-endian lane order in the SRAM.
                for (int b = 0; b < 4; b++) begin
                    check($sformatf("%s byte%0d", e.name, b), {24'd0, e.wdata[b*8 +: 8]},
                          {24'd0, sram_mem[e.addr[18:0] + 19'(b)]});
                end
            end
            chk_pins: begin
                check($sformatf("%s pins", e.name), e.exp_val, gpio_out);
                check($sformatf("%s led_r", e.name), {31'd0, ~e.exp_val[8]}, {31'd0, led_r});
                check($sformatf("%s led_g", e.name), {31'd0, ~e.exp_val[9]}, {31'd0, led_g});
                check($sformatf("%s led_b", e.name), {31'd0, ~e.exp_val[10]}, {31'd0, led_b});
            end
            chk_oe: begin
                check($sformatf("%s oe pins", e.name), e.exp_val, gpio_oe);
            end
            chk_shdn: begin
                check($sformatf("%s shdn", e.name), e.exp_val, {31'd0, shdn});
            end
            chk_reset: begin
                check($sformatf("%s soc_rst pulses", e.name), 32'd1,
                      32'(rst_pulses - pulses_before));
                check($sformatf("%s shdn", e.name), 32'd0, {31'd0, shdn});
                check($sformatf("%s pins", e.name), 32'd0, gpio_out);
                check($sformatf("%s oe pins", e.name), 32'd0, gpio_oe);
            end
            default: begin
            end
        endcase
        if (test_errors == 0) begin
            pass_count++;
            $display("PASS %s", e.name);
        end else begin
            fail_count++;
            $display("FAIL %s", e.name);
        end
    endtask

    initial begin
        bus_req     = '0;
        btn         = 2'b00;
        pass_count  = 0;
        fail_count  = 0;
        test_errors = 0;
        void'($urandom(32'ha7a8be25));
        build_stimulus();
        built = 1'b1;
        wait (rst_n);
        foreach (stim[i]) begin
            run_entry(stim[i]);
        end
        $display("Summary: %0d pass, %0d fail", pass_count, fail_count);
        if (fail_count == 0) begin
            $display("TESTS PASSED");
        end else begin
            $display("TESTS FAILED");
        end
        $finish;
    end

    // Watchdog sized from the stimulus length.
    initial begin
        wait (built);
        repeat (stim.size() * 20 + 200) @(posedge clk);
        $display("ERROR: run timed out after %0d cycles", stim.size() * 20 + 200);
        $display("TESTS FAILED");
        $finish;
    end

endmodule

`default_nettype wire

//--- test/boa_tb_clock.sv
// Testbench clock and reset
`timescale 1ns/1ps
`default_nettype none

module boa_tb_clock #(
    parameter int period_ns    = 20,
    parameter int reset_cycles = 2
) (
    output logic clk,
    output logic rst_n
);
    initial begin
        clk = 1'b0;
        forever #(period_ns / 2) clk = ~clk;
    end

    // Reset low for the first few rising edges.
    initial begin
        rst_n = 1'b0;
        repeat (reset_cycles) @(posedge clk);
        rst_n <= 1'b1;
    end

endmodule

`default_nettype wire
